// File: vlog.f
+incdir+bench
design/cart_pkg.sv
design/cart_bank_table.sv
design/cart_mapper.sv
design/cart_addr_xlate.sv
design/cartridge.sv
bench/cartridge_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing
TOP       ?= cartridge_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: bench/cart_tb_cases.svh
// One row per bus step, lines coded as {exrom, game}, a bank of -1 means the last random data
// **************************************************
// Case table
// **************************************************

task automatic load_case_table;
	// Generic 8K image, header EXROM 0 and GAME 1, packet 0 at bank 3
	add_case(OP_CART,   2'b01,    CART_GENERIC,    0);
	add_case(OP_LOAD,   0,        3,               16'h2000);
	add_case(OP_LINES,  0,        0,               2'b01);
	add_case(OP_ROML,   16'h8123, 0,               3);

	// Ocean, banks mirrored, packet 32 switches to the 512k layout
	add_case(OP_CART,   0,        CART_OCEAN,      0);
	add_case(OP_LINES,  0,        0,               2'b00);
	add_case(OP_IOE_WR, 16'hde00, -1,              0);
	add_case(OP_ROML,   16'h8456, 0,               -1);
	add_case(OP_ROMH,   16'ha789, 0,               -1);
	add_case(OP_IOE_WR, 16'hde00, -1,              0);
	add_case(OP_ROML,   16'h9fff, 0,               -1);
	add_case(OP_LOAD,   32,       40,              16'h2000);
	add_case(OP_LINES,  0,        0,               2'b01);

	// Magic Desk with 16 packets, bank is 4 bits wide
	add_case(OP_CART,   0,        CART_MAGIC_DESK, 0);
	add_case(OP_LOADN,  16,       0,               0);
	add_case(OP_LINES,  0,        0,               2'b01);
	add_case(OP_IOE_WR, 16'hde00, 8'hba,           0);
	add_case(OP_LINES,  0,        0,               2'b11);
	add_case(OP_ROML,   16'h8010, 0,               10);
	add_case(OP_IOE_WR, 16'hde00, 8'h35,           0);
	add_case(OP_LINES,  0,        0,               2'b01);
	add_case(OP_ROML,   16'h9abc, 0,               5);

	// Simons Basic, IOE read gives 8K mode and IOE write 16K mode
	add_case(OP_CART,   0,        CART_SIMONS,     0);
	add_case(OP_LINES,  0,        0,               2'b00);
	add_case(OP_IOE_RD, 16'hde00, 0,               0);
	add_case(OP_LINES,  0,        0,               2'b01);
	add_case(OP_IOE_WR, 16'hde00, 8'h00,           0);
	add_case(OP_LINES,  0,        0,               2'b00);

	// EasyFlash, boots in ultimax with two 16K packets in the table
	add_case(OP_CART,   0,        CART_EASYFLASH,  0);
	add_case(OP_LINES,  0,        0,               2'b10);
	add_case(OP_LOAD,   0,        0,               16'h4000);
	add_case(OP_LOAD,   1,        4,               16'h4000);
	add_case(OP_IOE_WR, 16'hde00, 8'h01,           0);
	add_case(OP_ROML,   16'h8200, 0,               4);
	add_case(OP_ROMH,   16'ha300, 0,               5);
	add_case(OP_IOE_WR, 16'hde00, 8'h00,           0);
	add_case(OP_ROMH,   16'he004, 0,               1);
	add_case(OP_IOE_WR, 16'hde02, 8'h07,           0);
	add_case(OP_LINES,  0,        0,               2'b00);
	add_case(OP_IOE_WR, 16'hde02, 8'h06,           0);
	add_case(OP_LINES,  0,        0,               2'b01);
	add_case(OP_IOE_WR, 16'hde02, 8'h00,           0);
	add_case(OP_LINES,  0,        0,               2'b10);
	add_case(OP_IOF_WR, 16'hdf05, 0,               0);
	add_case(OP_ULTIMAX, 16'h8800, 0,              0);
endtask

// File: bench/cartridge_tb.sv
// Runs the case table once, stops at the first wrong value, needs no input files
`timescale 1ns/1ps

module cartridge_tb;
	import cart_pkg::*;

	localparam int OP_CART    = 0;	// New type, d is the id, a the header lines
	localparam int OP_LOAD    = 1;	// One packet, d is its bank, e its size
	localparam int OP_LOADN   = 2;	// a packets of 8K at banks 0 up
	localparam int OP_IOE_WR  = 3;
	localparam int OP_IOE_RD  = 4;
	localparam int OP_LINES   = 5;	// Wait for {exrom, game} == e
	localparam int OP_ROML    = 6;
	localparam int OP_ROMH    = 7;
	localparam int OP_IOF_WR  = 8;
	localparam int OP_ULTIMAX = 9;

	typedef struct {
		int op;
		int a;
		int d;
		int e;
	} case_t;

	logic clk32 = 1'b0;
	logic reset_n;
	logic cart_loading, cart_bank_wr;
	cart_id_t cart_id;
	byte_t cart_exrom, cart_game, data_in;
	logic [15:0] cart_bank_laddr, cart_bank_size, cart_bank_num;
	mem_addr_t cart_bank_raddr, addr_out;
	logic exrom, game, romL, romH, IOE, IOF, mem_write, mem_ce;
	logic mem_ce_out, mem_write_out, IO_rom;
	cpu_addr_t addr_in;

	case_t cases[$];
	byte_t last_data;
	int    seed;

	always #5 clk32 = !clk32;

	cartridge #(.BANK_SLOTS(64)) dut_i (.*);

	task automatic add_case(input int op, input int a, input int d, input int e);
		cases.push_back('{op, a, d, e});
	endtask

	`include "cart_tb_cases.svh"

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("** FAIL **");
			$fatal(1, "Stopped on a wrong value");
		end
	endtask

	task automatic step;
		@(posedge clk32);
		#1;
	endtask

	// Address of a ROM bank byte as the memory layout defines it
	function automatic mem_addr_t rom_addr_of(input int bank, input cpu_addr_t a);
		return 23'h100000 + 23'(bank) * 23'h2000 + 23'(a[12:0]);
	endfunction

	task automatic put_packet(input int num, input int bank, input int size);
		cart_bank_wr    = 1'b1;
		cart_bank_num   = 16'(num);
		cart_bank_laddr = 16'h8000;
		cart_bank_size  = 16'(size);
		cart_bank_raddr = 23'h100000 + 23'(bank) * 23'h2000;
		step();
		cart_bank_wr = 1'b0;
	endtask

	task automatic ioe_access(input int a, input int d, input logic wr);
		step();		// IOE low at one edge, so the access below is a fresh strobe
		IOE       = 1'b1;
		mem_write = wr;
		addr_in   = 16'(a);
		data_in   = 8'(d);
		step();
		IOE       = 1'b0;
		mem_write = 1'b0;
	endtask

	task automatic wait_lines(input logic [1:0] exp);
		int n;
		n = 0;
		step();
		while ({exrom, game} !== exp && n < 8) begin	// Own timeout
			step();
			n++;
		end
		if ({exrom, game} !== exp) begin
			$display("Timeout: cartridge lines never reached the expected state");
			$display("** FAIL **");
			$fatal(1, "Line wait timed out");
		end
	endtask

	task automatic rom_read(input int a, input int bank, input logic hi);
		int b;
		b = bank < 0 ? int'(last_data[5:0]) : bank;
		romL    = !hi;
		romH    = hi;
		addr_in = 16'(a);
		#1;
		check(hi ? "addr_out romH" : "addr_out romL", 32'(addr_out), 32'(rom_addr_of(b, 16'(a))));
		romL = 1'b0;
		romH = 1'b0;
	endtask

	task automatic run_case(input case_t c);
		case (c.op)
			OP_CART: begin
				cart_loading = 1'b0;
				cart_id      = 16'(c.d);
				cart_exrom   = {7'd0, c.a[1]};
				cart_game    = {7'd0, c.a[0]};
				step();
				check("exrom on type change", 32'(exrom), 32'd1);
				check("game on type change", 32'(game), 32'd1);
				cart_loading = 1'b1;	// Rising edge clears the packet count
				step();
			end
			OP_LOAD:  put_packet(c.a, c.d, c.e);
			OP_LOADN: for (int i = 0; i < c.a; i++) put_packet(i, i, 16'h2000);
			OP_IOE_WR: begin
				if (c.d < 0)
					last_data = 8'($urandom);
				else
					last_data = 8'(c.d);
				ioe_access(c.a, last_data, 1'b1);
			end
			OP_IOE_RD: ioe_access(c.a, 0, 1'b0);
			OP_LINES:  wait_lines(2'(c.e));
			OP_ROML:   rom_read(c.a, c.e, 1'b0);
			OP_ROMH:   rom_read(c.a, c.e, 1'b1);
			OP_IOF_WR: begin
				IOF       = 1'b1;
				mem_write = 1'b1;
				addr_in   = 16'(c.a);
				#1;
				check("addr_out iof", 32'(addr_out), 32'(23'h010000 + 23'(addr_in[12:0])));
				check("IO_rom", 32'(IO_rom), 32'd1);
				check("mem_write_out iof", 32'(mem_write_out), 32'd1);	// Not under ROML
				check("mem_ce_out on IOF edge", 32'(mem_ce_out), 32'd1);
				step();
				check("mem_ce_out after IOF edge", 32'(mem_ce_out), 32'd0);
				IOF       = 1'b0;
				mem_write = 1'b0;
			end
			OP_ULTIMAX: begin
				romL      = 1'b1;
				mem_write = 1'b1;
				addr_in   = 16'(c.a);
				#1;
				check("mem_write_out ultimax", 32'(mem_write_out), 32'd0);
				romL      = 1'b0;
				mem_write = 1'b0;
			end
			default: begin
				$display("Unknown operation in the case table");
				$display("** FAIL **");
				$fatal(1, "Bad case row");
			end
		endcase
	endtask

	// **************************************************
	// Main sequence
	// **************************************************

	initial begin
		seed = $urandom(96106);
		reset_n = 1'b1;
		cart_loading = 1'b0;
		cart_bank_wr = 1'b0;
		cart_id = 16'hffff;	// No kept type, so the first row is a type change
		cart_exrom = '0;
		cart_game = '0;
		cart_bank_laddr = '0;
		cart_bank_size = '0;
		cart_bank_num = '0;
		cart_bank_raddr = '0;
		romL = 1'b1;	// Would map if reset did not hold it off
		romH = 1'b0;
		IOE = 1'b0;
		IOF = 1'b0;
		mem_write = 1'b0;
		mem_ce = 1'b0;
		addr_in = 16'h8123;
		data_in = '0;
		last_data = '0;
		load_case_table();

		repeat (10) begin
			step();
			check("addr_out in reset", 32'(addr_out), 32'h8123);
			check("exrom in reset", 32'(exrom), 32'd1);
			check("game in reset", 32'(game), 32'd1);
		end
		reset_n = 1'b0;
		romL    = 1'b0;

		foreach (cases[i])
			run_case(cases[i]);

		$display("** PASS **");
		$finish;
	end

endmodule

// File: design/cartridge.sv
// Expects the CRT image already in external memory, freezer and special I/O types are not handled
`timescale 1ns/1ps

module cartridge #(
	parameter int BANK_SLOTS = 64	// 16, 64 or 128 chip packets
) (
	input  logic                clk32,
	input  logic                reset_n,

	// Image load
	input  logic                cart_loading,
	input  cart_pkg::cart_id_t  cart_id,
	input  cart_pkg::byte_t     cart_exrom,
	input  cart_pkg::byte_t     cart_game,
	input  logic [15:0]         cart_bank_laddr,
	input  logic [15:0]         cart_bank_size,
	input  logic [15:0]         cart_bank_num,
	input  cart_pkg::mem_addr_t cart_bank_raddr,
	input  logic                cart_bank_wr,

	// Expansion port
	output logic                exrom,
	output logic                game,
	input  logic                romL,
	input  logic                romH,
	input  logic                IOE,
	input  logic                IOF,
	input  logic                mem_write,
	input  logic                mem_ce,
	output logic                mem_ce_out,
	output logic                mem_write_out,
	output logic                IO_rom,		// IOF access served from cartridge memory
	input  cart_pkg::cpu_addr_t addr_in,
	input  cart_pkg::byte_t     data_in,
	output cart_pkg::mem_addr_t addr_out
);
	import cart_pkg::*;

	bank_t tbl_index;
	bank_t lo_entry;
	bank_t hi_entry;
	byte_t bank_cnt;
	bank_t bank_lo;
	bank_t bank_hi;
	logic  iof_ena;
	logic  iof_wr_ena;

	cart_bank_table #(.BANK_SLOTS(BANK_SLOTS)) bank_table_i (
		.clk32, .reset_n, .cart_loading, .cart_bank_wr, .cart_bank_num,
		.cart_bank_laddr, .cart_bank_size, .cart_bank_raddr,
		.tbl_index, .lo_entry, .hi_entry, .bank_cnt
	);

	cart_mapper #(.BANK_SLOTS(BANK_SLOTS)) mapper_i (
		.clk32, .reset_n, .IOE, .mem_write, .cart_bank_wr,
		.cart_id, .cart_exrom, .cart_game, .data_in, .addr_in,
		.cart_bank_num, .lo_entry, .hi_entry, .bank_cnt,
		.tbl_index, .bank_lo, .bank_hi, .exrom, .game,
		.iof_ena, .iof_wr_ena
	);

	cart_addr_xlate xlate_i (
		.clk32, .reset_n, .romL, .romH, .IOF, .mem_write, .mem_ce,
		.exrom, .game, .iof_ena, .iof_wr_ena,
		.addr_in, .bank_lo, .bank_hi,
		.addr_out, .mem_write_out, .mem_ce_out, .IO_rom
	);

endmodule

// File: design/cart_addr_xlate.sv
// ROML and ROMH map only reads, IOF is the single I/O page mapped and always to bank 0
`timescale 1ns/1ps

module cart_addr_xlate (
	input  logic                clk32,
	input  logic                reset_n,
	input  logic                romL,		// $8000-$9FFF select
	input  logic                romH,		// $A000 or $E000 select
	input  logic                IOF,		// $DFxx select
	input  logic                mem_write,
	input  logic                mem_ce,
	input  logic                exrom,
	input  logic                game,
	input  logic                iof_ena,
	input  logic                iof_wr_ena,
	input  cart_pkg::cpu_addr_t addr_in,
	input  cart_pkg::bank_t     bank_lo,
	input  cart_pkg::bank_t     bank_hi,
	output cart_pkg::mem_addr_t addr_out,
	output logic                mem_write_out,
	output logic                mem_ce_out,
	output logic                IO_rom
);
	import cart_pkg::*;

	logic      iof_q;
	logic      stb_iof;
	logic      cs_iof;
	logic      ultimax;
	mem_addr_t bank_off;	// Offset inside the 8K bank

	always_ff @(posedge clk32) begin
		if (reset_n)
			iof_q <= 1'b0;
		else
			iof_q <= IOF;
	end

	assign stb_iof  = IOF && !iof_q;
	assign cs_iof   = IOF && (mem_write ? iof_wr_ena : iof_ena);
	assign ultimax  = exrom && !game;
	assign bank_off = mem_addr_t'(addr_in[12:0]);

	// **************************************************
	// Control outputs
	// **************************************************

	// No RAM sits under ROML in ultimax mode
	assign mem_write_out = mem_write && !(romL && ultimax);
	assign mem_ce_out    = mem_ce || (cs_iof && stb_iof);	// Extra access on the IOF edge
	assign IO_rom        = IOF && iof_ena;

	// **************************************************
	// Address translation
	// **************************************************

	always_comb begin
		addr_out = mem_addr_t'(addr_in);	// C64 RAM passes through
		if (!reset_n) begin
			if (romL && !mem_write)
				addr_out = rom_bank_addr(bank_lo, 1'b0) + bank_off;
			if (romH && !mem_write)
				addr_out = rom_bank_addr(bank_hi, 1'b0) + bank_off;
			// RAM page when writable, else ROM bank 0
			if (cs_iof)
				addr_out = rom_bank_addr('0, iof_wr_ena) + bank_off;
		end
	end

endmodule

// File: design/cart_mapper.sv
// Handles types 0, 4, 5, 19, 32 and 33 only, any other type keeps the reset line and bank state
`timescale 1ns/1ps

module cart_mapper #(
	parameter int BANK_SLOTS = 64	// Power of two, matches the bank table
) (
	input  logic                clk32,
	input  logic                reset_n,
	input  logic                IOE,		// $DExx select
	input  logic                mem_write,
	input  logic                cart_bank_wr,
	input  cart_pkg::cart_id_t  cart_id,
	input  cart_pkg::byte_t     cart_exrom,	// EXROM from the CRT header
	input  cart_pkg::byte_t     cart_game,	// GAME from the CRT header
	input  cart_pkg::byte_t     data_in,
	input  cart_pkg::cpu_addr_t addr_in,
	input  logic [15:0]         cart_bank_num,
	input  cart_pkg::bank_t     lo_entry,
	input  cart_pkg::bank_t     hi_entry,
	input  cart_pkg::byte_t     bank_cnt,
	output cart_pkg::bank_t     tbl_index,
	output cart_pkg::bank_t     bank_lo,
	output cart_pkg::bank_t     bank_hi,
	output logic                exrom,		// Active low
	output logic                game,		// Active low
	output logic                iof_ena,
	output logic                iof_wr_ena
);
	import cart_pkg::*;

	// Wraps EasyFlash bank numbers onto the table size
	localparam bank_t IDX_MASK = bank_t'(BANK_SLOTS - 1);

	logic     ioe_q;
	cart_id_t id_q;
	logic     init_n;		// Low for the one cycle that loads per-type defaults
	logic     id_changed;
	logic     stb_ioe;
	logic     ioe_wr;
	logic     ioe_rd;
	logic     ef_type;
	logic     ef_sel;

	// **************************************************
	// IOE strobe
	// **************************************************

	always_ff @(posedge clk32) begin
		if (reset_n)
			ioe_q <= 1'b0;
		else
			ioe_q <= IOE;
		id_q <= cart_id;	// Follows the type even in reset
	end

	assign id_changed = cart_id != id_q;
	assign stb_ioe    = IOE && !ioe_q;
	assign ioe_wr     = stb_ioe && mem_write;
	assign ioe_rd     = stb_ioe && !mem_write;

	// Table lookup only moves off entry 0 for an EasyFlash bank write
	assign ef_type = (cart_id == CART_EASYFLASH) || (cart_id == CART_XBANK);
	assign ef_sel  = ef_type && init_n && ioe_wr && !addr_in[1];

	always_comb begin
		tbl_index = '0;
		if (ef_sel)
			tbl_index = bank_t'(data_in[5:0]) & IDX_MASK;
	end

	// **************************************************
	// Per-type bank and line control
	// **************************************************

	always_ff @(posedge clk32) begin
		if (reset_n || id_changed) begin
			exrom      <= 1'b1;	// Cartridge invisible
			game       <= 1'b1;
			bank_lo    <= '0;
			bank_hi    <= '0;
			iof_ena    <= 1'b0;
			iof_wr_ena <= 1'b0;
			init_n     <= 1'b0;
		end else begin
			init_n <= 1'b1;
			case (cart_id)
				// Lines straight from the CRT header, fixed bank
				CART_GENERIC: begin
					exrom   <= cart_exrom[0];
					game    <= cart_game[0];
					bank_lo <= lo_entry;
					bank_hi <= hi_entry;
				end

				// Two 8K banks, IOE read gives 8K mode and IOE write 16K mode
				CART_SIMONS: begin
					if (!init_n) begin
						exrom   <= 1'b0;
						game    <= 1'b0;
						bank_lo <= 7'd0;
						bank_hi <= 7'd1;
					end else if (ioe_wr) begin
						game <= 1'b0;
					end else if (ioe_rd) begin
						game <= 1'b1;
					end
				end

				// Same bank mirrored at $8000 and $A000
				CART_OCEAN: begin
					if (!init_n) begin
						exrom <= 1'b0;
						game  <= 1'b0;
					end else begin
						if (ioe_wr) begin
							bank_lo <= bank_t'(data_in[5:0]);
							bank_hi <= bank_t'(data_in[5:0]);
						end
						// 512k image only maps $8000, $A000 stays RAM
						if (cart_bank_wr && cart_bank_num >= OCEAN_B_BANK)
							game <= 1'b1;
					end
				end

				// 8K mode, bank width follows the image size
				CART_MAGIC_DESK: begin
					if (!init_n) begin
						exrom   <= 1'b0;
						game    <= 1'b1;
						bank_lo <= 7'd0;
					end else if (ioe_wr) begin
						if (bank_cnt <= 8'd16)
							bank_lo <= bank_t'(data_in[3:0]);
						else if (bank_cnt <= 8'd32)
							bank_lo <= bank_t'(data_in[4:0]);
						else if (bank_cnt <= 8'd64)
							bank_lo <= bank_t'(data_in[5:0]);
						else
							bank_lo <= data_in[6:0];
						exrom <= data_in[7];	// Bit 7 switches the cartridge off
					end
				end

				// $DE00 bank, $DE02 control, RAM at $DFxx
				CART_EASYFLASH, CART_XBANK: begin
					if (!init_n) begin
						exrom      <= cart_id == CART_EASYFLASH;	// EasyFlash boots ultimax
						game       <= 1'b0;
						iof_ena    <= 1'b1;
						iof_wr_ena <= 1'b1;
						bank_lo    <= lo_entry;
						bank_hi    <= hi_entry;
					end else if (ioe_wr) begin
						if (addr_in[1]) begin
							game  <= !data_in[0] && data_in[2];	// Jumper in boot position
							exrom <= !data_in[1];
						end else begin
							bank_lo <= lo_entry;
							bank_hi <= hi_entry;
						end
					end
				end

				default: begin
				end
			endcase
		end
	end

endmodule

// File: design/cart_bank_table.sv
// BANK_SLOTS must be a power of two, packets numbered at or above it are ignored
`timescale 1ns/1ps

module cart_bank_table #(
	parameter int BANK_SLOTS = 64
) (
	input  logic                clk32,
	input  logic                reset_n,
	input  logic                cart_loading,	// High while the CRT image loads
	input  logic                cart_bank_wr,	// One pulse per chip packet
	input  logic [15:0]         cart_bank_num,
	input  logic [15:0]         cart_bank_laddr,	// Load address from the packet header
	input  logic [15:0]         cart_bank_size,
	input  cart_pkg::mem_addr_t cart_bank_raddr,	// Where the packet data landed
	input  cart_pkg::bank_t     tbl_index,
	output cart_pkg::bank_t     lo_entry,
	output cart_pkg::bank_t     hi_entry,
	output cart_pkg::byte_t     bank_cnt
);
	import cart_pkg::*;

	localparam int IDX_W = $clog2(BANK_SLOTS);
	localparam logic [15:0] SLOT_LIMIT = 16'(BANK_SLOTS);

	bank_t lo_banks [BANK_SLOTS];	// Bank seen at $8000
	bank_t hi_banks [BANK_SLOTS];	// Bank seen at $A000 or $E000
	bank_t raddr_bank;
	logic  loading_q;
	logic  slot_ok;

	assign raddr_bank = cart_cb_bank(cart_bank_raddr);
	assign slot_ok    = cart_bank_num < SLOT_LIMIT;

	// Packet bank from its position in external memory
	function automatic bank_t cart_cb_bank(input mem_addr_t raddr);
		return raddr[19:13];
	endfunction

	// Table fill
	always_ff @(posedge clk32) begin
		if (cart_bank_wr && slot_ok) begin
			if (cart_bank_laddr <= 16'h8000) begin
				lo_banks[cart_bank_num[IDX_W-1:0]] <= raddr_bank;
				// 16K packet also covers the upper half
				if (cart_bank_size > 16'h2000)
					hi_banks[cart_bank_num[IDX_W-1:0]] <= raddr_bank + 7'd1;
			end else begin
				hi_banks[cart_bank_num[IDX_W-1:0]] <= raddr_bank;
			end
		end
	end

	// Packet counter, restarts with each new image
	always_ff @(posedge clk32) begin
		if (reset_n) begin
			loading_q <= 1'b0;
			bank_cnt  <= '0;
		end else begin
			loading_q <= cart_loading;
			if (cart_loading && !loading_q)
				bank_cnt <= '0;
			else if (cart_bank_wr)
				bank_cnt <= bank_cnt + 8'd1;
		end
	end

	assign lo_entry = lo_banks[tbl_index[IDX_W-1:0]];	// Combinational read
	assign hi_entry = hi_banks[tbl_index[IDX_W-1:0]];

endmodule

// File: design/cart_pkg.sv
// Assumes 8K banks, a ROM image at 1 MB and cartridge RAM at 64K of external memory
package cart_pkg;

	// **************************************************
	// Widths
	// **************************************************

	typedef logic [15:0] cpu_addr_t;	// CPU address bus
	typedef logic [22:0] mem_addr_t;	// External memory address
	typedef logic [6:0]  bank_t;		// 8K bank number
	typedef logic [15:0] cart_id_t;		// CRT hardware type
	typedef logic [7:0]  byte_t;

	// **************************************************
	// CRT hardware type codes
	// **************************************************

	localparam cart_id_t CART_GENERIC    = 16'd0;
	localparam cart_id_t CART_SIMONS     = 16'd4;
	localparam cart_id_t CART_OCEAN      = 16'd5;
	localparam cart_id_t CART_MAGIC_DESK = 16'd19;
	localparam cart_id_t CART_EASYFLASH  = 16'd32;
	localparam cart_id_t CART_XBANK      = 16'd33;

	// **************************************************
	// Memory layout
	// **************************************************

	localparam int BANK_SHIFT = 13;				// 8K banks
	localparam mem_addr_t ROM_BASE = 23'h100000;	// Chip packets from the CRT file
	localparam mem_addr_t RAM_BASE = 23'h010000;	// Cartridge RAM, IOF page of EasyFlash

	// Packets numbered from here on mean a 512k Ocean image
	localparam logic [15:0] OCEAN_B_BANK = 16'd32;

	// Base address of a bank, the RAM flag overrides the bank number
	function automatic mem_addr_t rom_bank_addr(input bank_t bank, input logic ram);
		if (ram)
			return RAM_BASE;
		return ROM_BASE + (mem_addr_t'(bank) << BANK_SHIFT);
	endfunction

endpackage
